/* flist.f */
+incdir+design
design/video_pkg.sv
design/palette_prom.sv
design/prom_loader.sv
design/colour_mixer.sv
design/video_top.sv
tb/tb_clock.sv
tb/video_chk.sv
tb/video_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the palette mixer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module video_tb -f flist.f -o video_sim

# keep running past assertion errors so the testbench gives its verdict
./obj_dir/video_sim +verilator+error+limit+100 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* tb/video_tb.sv */
/*
 * video_tb: directed tests for the palette loader and colour mixer
 * reference palettes, rgb compare, watchdog and final report
 */

`default_nettype none

`include "video_defs.svh"

module video_tb;

    localparam int CLK_PERIOD = 8;
    localparam int PAL_SIZE = 1 << `VIDEO_PAL_AW;
    localparam int DL_SIZE = 1 << `VIDEO_DL_AW;
    // about 5 clocks per pixel check, one clock per download byte
    localparam int PIXEL_CHECKS = 96;
    localparam int DL_BYTES = 145;
    // 4x margin over the summed test length
    localparam int WATCHDOG_LIMIT = 4 * CLK_PERIOD * (5 * PIXEL_CHECKS + DL_BYTES);

    logic                  clk;
    logic                  rst;
    logic                  cen;
    logic                  cen_run;
    logic                  dl_we;
    video_pkg::dl_addr_t   dl_addr;
    video_pkg::dl_byte_t   dl_data;
    logic                  hblank_n;
    logic                  vblank_n;
    video_pkg::bak_code_t  bakc;
    video_pkg::obj_bank_t  objc;
    video_pkg::obj_pix_t   objv;
    video_pkg::txt_code_t  txtc;
    logic                  txtv;
    logic [2:0]            red;
    logic [2:0]            green;
    logic [1:0]            blue;

    // mirror of every byte sent down the stream
    video_pkg::rgb_t       bak_ref [0:PAL_SIZE-1];
    logic [3:0]            objlo_ref [0:PAL_SIZE-1];
    logic [3:0]            objhi_ref [0:PAL_SIZE-1];
    video_pkg::rgb_t       txt_ref [0:PAL_SIZE-1];

    int pass_count = 0;
    int fail_count = 0;
    int test_errors = 0;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (
        .clk (clk)
    );

    video_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .dl_we    (dl_we),
        .dl_addr  (dl_addr),
        .dl_data  (dl_data),
        .hblank_n (hblank_n),
        .vblank_n (vblank_n),
        .bakc     (bakc),
        .objc     (objc),
        .objv     (objv),
        .txtc     (txtc),
        .txtv     (txtv),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    // pixel enable every second clock, parked low when cen_run drops
    always @(posedge clk) begin
        #1;
        cen <= cen_run && !cen;
    end

    // priority rule on the reference palettes
    function automatic video_pkg::rgb_t expected_rgb(
        input logic hb,
        input logic vb,
        input video_pkg::bak_code_t b,
        input video_pkg::obj_bank_t oc,
        input video_pkg::obj_pix_t ov,
        input video_pkg::txt_code_t tc,
        input logic tv
    );
        video_pkg::pal_addr_t obj_idx;
        obj_idx = {oc, ov};
        if (!tv) begin
            return txt_ref[{1'b0, tc}];
        end else if (ov != 2'd0) begin
            return {objhi_ref[obj_idx], objlo_ref[obj_idx]};
        end else if (hb && vb) begin
            return bak_ref[b];
        end else begin
            return 8'h00;
        end
    endfunction

    task automatic check_rgb(input video_pkg::rgb_t expected, input video_pkg::rgb_t actual);
        if (actual !== expected) begin
            $display("Error rgb expected %02h actual %02h at %0t", expected, actual, $time);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    // returns just after a clock edge that had cen high
    task automatic wait_cen();
        @(posedge clk);
        while (cen !== 1'b1) begin
            @(posedge clk);
        end
        #1;
    endtask

    // one byte per clock, mirrored into the reference palettes
    task automatic send_byte(input video_pkg::dl_addr_t a, input video_pkg::dl_byte_t d);
        dl_we = 1'b1;
        dl_addr = a;
        dl_data = d;
        case (a[`VIDEO_DL_AW-1:`VIDEO_PAL_AW])
            `VIDEO_REG_BAK:    bak_ref[a[`VIDEO_PAL_AW-1:0]] = d;
            `VIDEO_REG_OBJ_LO: objlo_ref[a[`VIDEO_PAL_AW-1:0]] = d[3:0];
            `VIDEO_REG_OBJ_HI: objhi_ref[a[`VIDEO_PAL_AW-1:0]] = d[7:4];
            default:           txt_ref[a[`VIDEO_PAL_AW-1:0]] = d;
        endcase
        @(posedge clk);
        #1;
        dl_we = 1'b0;
    endtask

    // strobe and PROM write trail the last byte by 2 clocks
    task automatic finish_load();
        repeat (2) @(posedge clk);
        #1;
    endtask

    // drive one pixel, result 2 cen edges later
    task automatic show_pixel(
        input logic hb,
        input logic vb,
        input video_pkg::bak_code_t b,
        input video_pkg::obj_bank_t oc,
        input video_pkg::obj_pix_t ov,
        input video_pkg::txt_code_t tc,
        input logic tv
    );
        hblank_n = hb;
        vblank_n = vb;
        bakc = b;
        objc = oc;
        objv = ov;
        txtc = tc;
        txtv = tv;
        wait_cen();
        wait_cen();
        check_rgb(expected_rgb(hb, vb, b, oc, ov, tc, tv), {red, green, blue});
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic load_and_text();
        for (int i = 0; i < DL_SIZE; i++) begin
            send_byte(video_pkg::dl_addr_t'(i), video_pkg::dl_byte_t'($urandom));
        end
        finish_load();
        // text wins over everything
        for (int i = 0; i < 16; i++) begin
            show_pixel(1'($urandom), 1'($urandom), video_pkg::bak_code_t'($urandom),
                video_pkg::obj_bank_t'($urandom), video_pkg::obj_pix_t'($urandom),
                video_pkg::txt_code_t'($urandom), 1'b0);
        end
        end_test("load and text priority");
    endtask

    task automatic object_over_background();
        for (int b = 0; b < 8; b++) begin
            for (int p = 1; p < 4; p++) begin
                show_pixel(1'b1, 1'b1, video_pkg::bak_code_t'($urandom),
                    video_pkg::obj_bank_t'(b), video_pkg::obj_pix_t'(p),
                    video_pkg::txt_code_t'($urandom), 1'b1);
            end
        end
        end_test("object over background");
    endtask

    task automatic background_only();
        for (int i = 0; i < PAL_SIZE; i++) begin
            show_pixel(1'b1, 1'b1, video_pkg::bak_code_t'(i), video_pkg::obj_bank_t'($urandom),
                2'd0, video_pkg::txt_code_t'($urandom), 1'b1);
        end
        end_test("background");
    endtask

    task automatic blanking();
        // h only, v only, both
        for (int k = 0; k < 12; k++) begin
            show_pixel(k % 3 == 1, k % 3 == 0, video_pkg::bak_code_t'($urandom),
                video_pkg::obj_bank_t'($urandom), 2'd0, video_pkg::txt_code_t'($urandom), 1'b1);
        end
        // text still shows while blanked
        for (int k = 0; k < 4; k++) begin
            show_pixel(1'b0, 1'($urandom), video_pkg::bak_code_t'($urandom),
                video_pkg::obj_bank_t'($urandom), video_pkg::obj_pix_t'($urandom),
                video_pkg::txt_code_t'($urandom), 1'b0);
        end
        end_test("blanking");
    endtask

    task automatic reload_entries();
        video_pkg::pal_addr_t e;
        // background entry 9, neighbour 10 untouched
        e = 5'd9;
        send_byte({`VIDEO_REG_BAK, e}, ~bak_ref[e]);
        finish_load();
        show_pixel(1'b1, 1'b1, e, 3'd0, 2'd0, 4'd0, 1'b1);
        show_pixel(1'b1, 1'b1, 5'd10, 3'd0, 2'd0, 4'd0, 1'b1);
        // object entry bank 5, pixel 2, one nibble at a time
        e = {3'd5, 2'd2};
        send_byte({`VIDEO_REG_OBJ_LO, e}, {4'h0, ~objlo_ref[e]});
        finish_load();
        show_pixel(1'b1, 1'b1, 5'd0, 3'd5, 2'd2, 4'd0, 1'b1);
        send_byte({`VIDEO_REG_OBJ_HI, e}, {~objhi_ref[e], 4'h0});
        finish_load();
        show_pixel(1'b1, 1'b1, 5'd0, 3'd5, 2'd2, 4'd0, 1'b1);
        show_pixel(1'b1, 1'b1, 5'd0, 3'd5, 2'd3, 4'd0, 1'b1);
        // text entry 7, neighbour 8
        e = 5'd7;
        send_byte({`VIDEO_REG_TXT, e}, ~txt_ref[e]);
        finish_load();
        show_pixel(1'b1, 1'b1, 5'd0, 3'd0, 2'd0, 4'd7, 1'b0);
        show_pixel(1'b1, 1'b1, 5'd0, 3'd0, 2'd0, 4'd8, 1'b0);
        end_test("reload");
    endtask

    task automatic cen_hold();
        video_pkg::rgb_t held;
        show_pixel(1'b1, 1'b1, 5'd3, 3'd0, 2'd0, 4'd0, 1'b1);
        cen_run = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        held = {red, green, blue};
        check_rgb(expected_rgb(1'b1, 1'b1, 5'd3, 3'd0, 2'd0, 4'd0, 1'b1), held);
        // inputs move, pipeline must not
        for (int i = 0; i < 6; i++) begin
            hblank_n = 1'($urandom);
            vblank_n = 1'($urandom);
            bakc = video_pkg::bak_code_t'($urandom);
            objc = video_pkg::obj_bank_t'($urandom);
            objv = video_pkg::obj_pix_t'($urandom);
            txtc = video_pkg::txt_code_t'($urandom);
            txtv = 1'($urandom);
            @(posedge clk);
            #1;
            check_rgb(held, {red, green, blue});
        end
        cen_run = 1'b1;
        // new text pixel enters while the held stage 1 drains out
        hblank_n = 1'b1;
        vblank_n = 1'b1;
        bakc = 5'd0;
        objc = 3'd0;
        objv = 2'd0;
        txtc = 4'd9;
        txtv = 1'b0;
        wait_cen();
        check_rgb(held, {red, green, blue});
        wait_cen();
        check_rgb(expected_rgb(1'b1, 1'b1, 5'd0, 3'd0, 2'd0, 4'd9, 1'b0), {red, green, blue});
        end_test("clock enable hold");
    endtask

    initial begin
        void'($urandom(32'h42a7f0d3));
        rst = 1'b1;
        cen = 1'b0;
        cen_run = 1'b1;
        dl_we = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        hblank_n = 1'b0;
        vblank_n = 1'b0;
        bakc = '0;
        objc = '0;
        objv = '0;
        txtc = '0;
        txtv = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        load_and_text();
        object_over_background();
        background_only();
        blanking();
        reload_entries();
        cen_hold();

        if (i_dut.u_mixer.i_chk.failed) begin
            $display("a concurrent assertion in the bound checker failed");
            fail_count++;
        end
        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_LIMIT);
        $display("watchdog timeout, tests did not finish in %0d time units", WATCHDOG_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/video_chk.sv */
/*
 * video_chk: concurrent checks bound into colour_mixer
 * loader write strobes, blanked select and cen hold of the RGB register
 */

`default_nettype none

module video_chk (
    input wire                    clk,
    input wire                    rst,
    input wire                    cen,
    input wire                    bak_we,
    input wire                    objlo_we,
    input wire                    objhi_we,
    input wire                    txt_we,
    input wire video_pkg::layer_t sel,
    input wire video_pkg::rgb_t   rgb_q
);

    // sticky, set by any failing property
    logic failed = 1'b0;

    // loader decodes one region per byte
    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({bak_we, objlo_we, objhi_we, txt_we}))
    else begin
        failed = 1'b1;
        $error("more than one palette write strobe high");
    end

    // no layer taken, black on the next stage
    none_is_black: assert property (@(posedge clk) disable iff (rst)
        (cen && sel == video_pkg::LAYER_NONE) |=> (rgb_q == '0))
    else begin
        failed = 1'b1;
        $error("rgb not black after a LAYER_NONE select");
    end

    // output register holds between pixel enables
    hold_without_cen: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(rgb_q))
    else begin
        failed = 1'b1;
        $error("rgb changed on a clock with cen low");
    end

endmodule

// strobes arrive here as mixer inputs
bind colour_mixer video_chk i_chk (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .bak_we   (bak_we),
    .objlo_we (objlo_we),
    .objhi_we (objhi_we),
    .txt_we   (txt_we),
    .sel      (sel),
    .rgb_q    (rgb_q)
);

`default_nettype wire

/* tb/tb_clock.sv */
/*
 * tb_clock: free running testbench clock
 */

`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    // half period per phase
    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* design/video_top.sv */
/*
 * video_top: palette download loader and colour mixer
 */

`default_nettype none

`include "video_defs.svh"

module video_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cen,
    input  wire                        dl_we,
    input  wire [`VIDEO_DL_AW-1:0]     dl_addr,
    input  wire video_pkg::dl_byte_t   dl_data,
    input  wire                        hblank_n,
    input  wire                        vblank_n,
    input  wire video_pkg::bak_code_t  bakc,
    input  wire video_pkg::obj_bank_t  objc,
    input  wire video_pkg::obj_pix_t   objv,
    input  wire video_pkg::txt_code_t  txtc,
    input  wire                        txtv,
    output wire [2:0]                  red,
    output wire [2:0]                  green,
    output wire [1:0]                  blue
);

    // loader to mixer
    wire [`VIDEO_PAL_AW-1:0] pal_wr_addr;
    video_pkg::dl_byte_t     pal_wr_data;
    wire                     bak_we;
    wire                     objlo_we;
    wire                     objhi_we;
    wire                     txt_we;

    prom_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .dl_we       (dl_we),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .pal_wr_addr (pal_wr_addr),
        .pal_wr_data (pal_wr_data),
        .bak_we      (bak_we),
        .objlo_we    (objlo_we),
        .objhi_we    (objhi_we),
        .txt_we      (txt_we)
    );

    colour_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .hblank_n    (hblank_n),
        .vblank_n    (vblank_n),
        .bakc        (bakc),
        .objc        (objc),
        .objv        (objv),
        .txtc        (txtc),
        .txtv        (txtv),
        .pal_wr_addr (pal_wr_addr),
        .pal_wr_data (pal_wr_data),
        .bak_we      (bak_we),
        .objlo_we    (objlo_we),
        .objhi_we    (objhi_we),
        .txt_we      (txt_we),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

`default_nettype wire

/* design/colour_mixer.sv */
/*
 * colour_mixer: fixed layer priority, four palette PROMs
 * and the registered 3-3-2 RGB output, two cen stages deep
 */

`default_nettype none

`include "video_defs.svh"

module colour_mixer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cen,
    input  wire                        hblank_n,
    input  wire                        vblank_n,
    input  wire video_pkg::bak_code_t  bakc,
    input  wire video_pkg::obj_bank_t  objc,
    input  wire video_pkg::obj_pix_t   objv,
    input  wire video_pkg::txt_code_t  txtc,
    input  wire                        txtv,
    input  wire video_pkg::pal_addr_t  pal_wr_addr,
    input  wire video_pkg::dl_byte_t   pal_wr_data,
    input  wire                        bak_we,
    input  wire                        objlo_we,
    input  wire                        objhi_we,
    input  wire                        txt_we,
    output logic [2:0]                 red,
    output logic [2:0]                 green,
    output logic [1:0]                 blue
);

    video_pkg::rgb_t      bak_rgb;
    video_pkg::rgb_t      obj_rgb;
    video_pkg::rgb_t      txt_rgb;
    video_pkg::rgb_t      mix_rgb;
    video_pkg::rgb_t      rgb_q;
    video_pkg::pal_addr_t obj_addr;
    video_pkg::pal_addr_t txt_addr;
    video_pkg::layer_t    sel_next;
    video_pkg::layer_t    sel;

    // bank in the high bits, pixel value below
    assign obj_addr = {objc, objv};
    // text codes only reach the lower half of the PROM
    assign txt_addr = {{(`VIDEO_PAL_AW - $bits(video_pkg::txt_code_t)){1'b0}}, txtc};

    // priority on the raw pixel inputs
    always_comb begin
        if (!txtv) begin
            sel_next = video_pkg::LAYER_TXT;    // txtv is active low
        end else if (objv != '0) begin
            sel_next = video_pkg::LAYER_OBJ;
        end else if (hblank_n && vblank_n) begin
            sel_next = video_pkg::LAYER_BAK;
        end else begin
            sel_next = video_pkg::LAYER_NONE;   // blanked, black
        end
    end

    // stage 1, in step with the PROM reads
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= video_pkg::LAYER_NONE;
        end else if (cen) begin
            sel <= sel_next;
        end
    end

    // pick the registered palette word
    always_comb begin
        case (sel)
            video_pkg::LAYER_TXT: mix_rgb = txt_rgb;
            video_pkg::LAYER_OBJ: mix_rgb = obj_rgb;
            video_pkg::LAYER_BAK: mix_rgb = bak_rgb;
            default:              mix_rgb = '0;
        endcase
    end

    // stage 2, output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_q <= '0;
        end else if (cen) begin
            rgb_q <= mix_rgb;
        end
    end

    assign {red, green, blue} = rgb_q;

    // background palette
    palette_prom #(.WIDTH(8)) u_bak_prom (
        .clk     (clk),
        .cen     (cen),
        .rd_addr (bakc),
        .wr_addr (pal_wr_addr),
        .we      (bak_we),
        .wr_data (pal_wr_data),
        .q       (bak_rgb)
    );

    // object palette, low nibble from its own region
    palette_prom #(.WIDTH(4)) u_objlo_prom (
        .clk     (clk),
        .cen     (cen),
        .rd_addr (obj_addr),
        .wr_addr (pal_wr_addr),
        .we      (objlo_we),
        .wr_data (pal_wr_data[3:0]),
        .q       (obj_rgb[3:0])
    );

    // high nibble takes the upper data bits
    palette_prom #(.WIDTH(4)) u_objhi_prom (
        .clk     (clk),
        .cen     (cen),
        .rd_addr (obj_addr),
        .wr_addr (pal_wr_addr),
        .we      (objhi_we),
        .wr_data (pal_wr_data[7:4]),
        .q       (obj_rgb[7:4])
    );

    // text palette
    palette_prom #(.WIDTH(8)) u_txt_prom (
        .clk     (clk),
        .cen     (cen),
        .rd_addr (txt_addr),
        .wr_addr (pal_wr_addr),
        .we      (txt_we),
        .wr_data (pal_wr_data),
        .q       (txt_rgb)
    );

endmodule

`default_nettype wire

/* design/prom_loader.sv */
/*
 * prom_loader: byte download decoder
 * registers address and data, one registered write strobe per palette PROM
 */

`default_nettype none

`include "video_defs.svh"

module prom_loader (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        dl_we,
    input  wire video_pkg::dl_addr_t   dl_addr,
    input  wire video_pkg::dl_byte_t   dl_data,
    output video_pkg::pal_addr_t       pal_wr_addr,
    output video_pkg::dl_byte_t        pal_wr_data,
    output logic                       bak_we,
    output logic                       objlo_we,
    output logic                       objhi_we,
    output logic                       txt_we
);

    // top bits pick the PROM
    logic [`VIDEO_DL_AW-`VIDEO_PAL_AW-1:0] region;
    // low bits are the entry inside it
    video_pkg::pal_addr_t                  entry;

    assign region = dl_addr[`VIDEO_DL_AW-1:`VIDEO_PAL_AW];
    assign entry  = dl_addr[`VIDEO_PAL_AW-1:0];

    // payload, only captured with a valid byte
    // so address and data are settled while the strobe is up
    always_ff @(posedge clk) begin
        if (dl_we) begin
            pal_wr_addr <= entry;
            pal_wr_data <= dl_data;
        end
    end

    // one strobe for one clock after the byte
    always_ff @(posedge clk) begin
        if (rst) begin
            bak_we   <= 1'b0;
            objlo_we <= 1'b0;
            objhi_we <= 1'b0;
            txt_we   <= 1'b0;
        end else begin
            bak_we   <= 1'b0;
            objlo_we <= 1'b0;
            objhi_we <= 1'b0;
            txt_we   <= 1'b0;
            if (dl_we) begin
                case (region)
                    `VIDEO_REG_BAK:    bak_we   <= 1'b1;
                    `VIDEO_REG_OBJ_LO: objlo_we <= 1'b1;
                    `VIDEO_REG_OBJ_HI: objhi_we <= 1'b1;
                    `VIDEO_REG_TXT:    txt_we   <= 1'b1;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/palette_prom.sv */
/*
 * palette_prom: 32-entry writeable palette memory
 * write on any clock with we, registered read on cen only
 */

`default_nettype none

`include "video_defs.svh"

module palette_prom #(
    parameter int WIDTH = 8
) (
    input  wire                       clk,
    input  wire                       cen,
    input  wire video_pkg::pal_addr_t rd_addr,
    input  wire video_pkg::pal_addr_t wr_addr,
    input  wire                       we,
    input  wire [WIDTH-1:0]           wr_data,
    output logic [WIDTH-1:0]          q
);

    // contents come from the download, no init
    logic [WIDTH-1:0] mem [0:(1 << `VIDEO_PAL_AW)-1];

    // loader strobe, not tied to the pixel rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // first pipeline stage of the mixer
    // holds while cen is low
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* design/video_pkg.sv */
/*
 * video_pkg: colour code, RGB and download typedefs
 * plus the layer select enum used by the mixer
 */

`default_nettype none

`include "video_defs.svh"

package video_pkg;

    // palette PROM address
    typedef logic [`VIDEO_PAL_AW-1:0] pal_addr_t;

    // per layer colour codes
    typedef logic [4:0] bak_code_t;
    typedef logic [2:0] obj_bank_t;
    // 0 is transparent
    typedef logic [1:0] obj_pix_t;
    typedef logic [3:0] txt_code_t;

    // red 3, green 3, blue 2 from the MSB down
    typedef logic [7:0] rgb_t;

    // download stream
    typedef logic [`VIDEO_DL_AW-1:0] dl_addr_t;
    typedef logic [7:0] dl_byte_t;

    // winning layer for one pixel
    typedef enum logic [1:0] {
        LAYER_NONE,
        LAYER_TXT,
        LAYER_OBJ,
        LAYER_BAK
    } layer_t;

endpackage

`default_nettype wire

/* design/video_defs.svh */
/*
 * widths and download region map for the palette subsystem
 * regions are 32 bytes each, picked by the top two download address bits
 */

`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// palette PROM address width, 32 entries per PROM
`define VIDEO_PAL_AW 5

// download address width, four regions of 32 bytes
`define VIDEO_DL_AW 7

// region codes, compared against dl_addr[VIDEO_DL_AW-1:VIDEO_PAL_AW]
`define VIDEO_REG_BAK 2'd0
// object palette split in two 4-bit PROMs
`define VIDEO_REG_OBJ_LO 2'd1
`define VIDEO_REG_OBJ_HI 2'd2
`define VIDEO_REG_TXT 2'd3

`endif
